// ==== arb_pkg.sv ====
package arb_pkg;

  import flow_pkg::*;

  // ------------------------------
  // Arbitration types
  // ------------------------------

  // One bit per flow
  // Used for request, grant, can_grant, valid and ready vectors
  typedef logic [NUM_FLOWS-1:0] flow_mask_t;

  // Occupancy of the one-entry egress register
  typedef enum logic {
    EGR_EMPTY = 1'b0,
    EGR_FULL  = 1'b1
  } egress_state_t;

endpackage : arb_pkg

// ==== flow_arb_chk.sv ====
`timescale 1ns/10ps

module flow_arb_chk
  import arb_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input flow_mask_t grant,
  input flow_mask_t req_valid,
  input flow_mask_t req_ready,
  input logic       pop_valid,
  input logic       pop_ready
);

  // At most one winner per cycle
  grant_onehot0: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else $error("grant selects more than one flow");

  // A slot empties only together with a pop into egress
  push_implies_pop: assert property (@(posedge clk) disable iff (!rst_n)
    |(req_valid & req_ready) |-> (pop_valid && pop_ready))
    else $error("slot handshake without a pop handshake");

  // Stalled egress blocks every slot
  ready_needs_pop: assert property (@(posedge clk) disable iff (!rst_n)
    !pop_ready |-> (req_ready == '0))
    else $error("req_ready high while pop_ready is low");

endmodule : flow_arb_chk

// Core handshakes as wired in the top level, where the clock is
bind flow_arb_top flow_arb_chk chk_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .grant     (grant),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .pop_valid (pop_valid),
  .pop_ready (pop_ready)
);

// ==== flow_arb_core.sv ====
`timescale 1ns/10ps

module flow_arb_core
  import flow_pkg::*, arb_pkg::*;
(
  // Base arbiter side
  output flow_mask_t request,
  input  flow_mask_t can_grant,
  input  flow_mask_t grant,
  output logic       enable_priority_update,
  // Ready/valid from the ingress slots
  input  flow_mask_t req_valid,
  output flow_mask_t req_ready,
  // Merged stream toward egress
  input  logic       pop_ready,
  output logic       pop_valid,
  output flow_id_t   pop_flow
);

  // ------------------------------
  // Arbiter hookup
  // ------------------------------

  // Every valid flow competes
  assign request = req_valid;

  // Pointer moves only when the winner is really taken
  assign enable_priority_update = pop_ready;

  // Only the winner sees ready, and only if egress can accept
  assign req_ready = {NUM_FLOWS{pop_ready}} & can_grant;

  // Arbiter always grants, so any valid flow means a pop
  assign pop_valid = |req_valid;

  // ------------------------------
  // Winner encoding
  // ------------------------------

  // One-hot grant to index, OR of the set bit positions
  always_comb begin
    pop_flow = '0;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      if (grant[i]) begin
        pop_flow = pop_flow | flow_id_t'(i);
      end
    end
  end

endmodule : flow_arb_core

// ==== flow_arb_monitor.sv ====
`timescale 1ns/10ps

module flow_arb_monitor
  import flow_pkg::*, arb_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input flow_mask_t in_valid,
  input payload_t   in_data [NUM_FLOWS],
  input flow_mask_t in_ready,
  input logic       out_valid,
  input logic       out_ready,
  input payload_t   out_data,
  input flow_id_t   out_flow
);

  // Accepted items not yet seen on the output, in push order
  typedef struct packed {
    flow_id_t flow;
    payload_t data;
  } item_t;
  item_t pend_q [$];

  int push_count = 0;
  int pop_count  = 0;
  int err_count  = 0;

  // Output stalled on the last edge and what it showed then
  logic     stall_q = 1'b0;
  payload_t held_data;
  flow_id_t held_flow;

  // Oldest pending item of the flow that came out
  // Else the oldest item overall so a wrong tag shows both values
  function automatic int expected_item(input flow_id_t got_flow);
    int idx;
    idx = -1;
    for (int i = 0; i < pend_q.size(); i++) begin
      if (idx < 0 && pend_q[i].flow == got_flow) begin
        idx = i;
      end
    end
    if (idx < 0 && pend_q.size() > 0) begin
      idx = 0;
    end
    return idx;
  endfunction

  // ------------------------------
  // Compare on every edge
  // ------------------------------

  always @(posedge clk) begin : compare
    int    idx;
    item_t want;
    if (rst_n) begin
      // A stalled item stays valid and unchanged
      if (stall_q && !out_valid) begin
        $display("error at %0t: stalled out_valid expected 1 got %b", $time, out_valid);
        err_count++;
      end else if (stall_q && (out_data !== held_data || out_flow !== held_flow)) begin
        $display("error at %0t: stalled out_data/out_flow expected %h/%0d got %h/%0d",
                 $time, held_data, held_flow, out_data, out_flow);
        err_count++;
      end
      if (out_valid && out_ready) begin
        pop_count++;
        idx = expected_item(out_flow);
        if (idx < 0) begin
          $display("item out at %0t on flow %0d with nothing pending", $time, out_flow);
          err_count++;
        end else begin
          want = pend_q[idx];
          if (out_flow !== want.flow) begin
            $display("error at %0t: out_flow expected %0d got %0d", $time, want.flow, out_flow);
            err_count++;
          end
          if (out_data !== want.data) begin
            $display("error at %0t: out_data expected %h got %h", $time, want.data, out_data);
            err_count++;
          end
          pend_q.delete(idx);
        end
      end
      // Accepted pushes join the pending list
      for (int i = 0; i < NUM_FLOWS; i++) begin
        if (in_valid[i] && in_ready[i]) begin
          pend_q.push_back({flow_id_t'(i), in_data[i]});
          push_count++;
        end
      end
    end
    stall_q   <= rst_n && out_valid && !out_ready;
    held_data <= out_data;
    held_flow <= out_flow;
  end

endmodule : flow_arb_monitor

// ==== flow_arb_top.sv ====
`timescale 1ns/10ps

module flow_arb_top
  import flow_pkg::*, arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Push side, one ready/valid pair per flow
  input  flow_mask_t in_valid,
  input  payload_t   in_data [NUM_FLOWS],
  output flow_mask_t in_ready,
  // Merged pop side
  output logic       out_valid,
  input  logic       out_ready,
  output payload_t   out_data,
  output flow_id_t   out_flow
);

  // ------------------------------
  // Internal wires
  // ------------------------------

  // Ingress to core
  flow_mask_t req_valid;
  flow_mask_t req_ready;
  payload_t   req_data [NUM_FLOWS];

  // Core to base arbiter
  flow_mask_t request;
  flow_mask_t grant;
  flow_mask_t can_grant;
  logic       enable_priority_update;

  // Core to egress
  logic       pop_valid;
  logic       pop_ready;
  flow_id_t   pop_flow;

  // ------------------------------
  // Instances
  // ------------------------------

  // Per-flow registered slots
  flow_ingress ingress_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .req_valid (req_valid),
    .req_data  (req_data),
    .req_ready (req_ready)
  );

  // Round-robin base arbiter
  rr_arbiter arbiter_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .request                (request),
    .enable_priority_update (enable_priority_update),
    .grant                  (grant),
    .can_grant              (can_grant)
  );

  // Flow control between slots, arbiter and egress
  flow_arb_core core_i (
    .request                (request),
    .can_grant              (can_grant),
    .grant                  (grant),
    .enable_priority_update (enable_priority_update),
    .req_valid              (req_valid),
    .req_ready              (req_ready),
    .pop_ready              (pop_ready),
    .pop_valid              (pop_valid),
    .pop_flow               (pop_flow)
  );

  // One-entry output register
  flow_egress egress_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pop_valid (pop_valid),
    .pop_flow  (pop_flow),
    .req_data  (req_data),
    .pop_ready (pop_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_flow  (out_flow)
  );

endmodule : flow_arb_top

// ==== flow_egress.sv ====
`timescale 1ns/10ps

module flow_egress
  import flow_pkg::*, arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Winner from the arbiter core
  input  logic     pop_valid,
  input  flow_id_t pop_flow,
  input  payload_t req_data [NUM_FLOWS],
  output logic     pop_ready,
  // External pop side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data,
  output flow_id_t out_flow
);

  // ------------------------------
  // Register and state
  // ------------------------------

  egress_state_t state_q;
  egress_state_t state_d;
  // Held item and its source tag
  payload_t      data_q;
  flow_id_t      flow_q;
  // Payload of the current winner
  payload_t      sel_data;
  // Pop handshake into the register
  logic          load;

  assign sel_data = req_data[pop_flow];

  // Room when empty, or when the held item leaves this cycle
  assign pop_ready = (state_q == EGR_EMPTY) || out_ready;
  assign load      = pop_valid && pop_ready;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      EGR_EMPTY: begin
        if (load) begin
          state_d = EGR_FULL;
        end
      end
      EGR_FULL: begin
        // Item leaves with nothing behind it
        // A leave with a new pop stays full and reloads
        if (out_ready && !load) begin
          state_d = EGR_EMPTY;
        end
      end
      default: begin
        state_d = EGR_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= EGR_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload and tag, written only on a pop so they hold under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= sel_data;
      flow_q <= pop_flow;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  assign out_valid = (state_q == EGR_FULL);
  assign out_data  = data_q;
  assign out_flow  = flow_q;

endmodule : flow_egress

// ==== flow_ingress.sv ====
`timescale 1ns/10ps

module flow_ingress
  import flow_pkg::*, arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Push side from the external sources
  input  flow_mask_t in_valid,
  input  payload_t   in_data [NUM_FLOWS],
  output flow_mask_t in_ready,
  // Registered requests toward the arbiter core
  output flow_mask_t req_valid,
  output payload_t   req_data [NUM_FLOWS],
  input  flow_mask_t req_ready
);

  // ------------------------------
  // Slot storage
  // ------------------------------

  // One occupancy flag per flow
  flow_mask_t full_q;
  // Payload held by each slot
  payload_t   data_q [NUM_FLOWS];

  // Handshakes on both sides of the slots
  flow_mask_t push;
  flow_mask_t pop;

  assign push = in_valid & in_ready;
  assign pop  = req_valid & req_ready;

  // Occupancy flags
  // Push needs an empty slot and pop needs a full one,
  // so both never hit the same slot on one edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= '0;
    end else begin
      full_q <= (full_q | push) & ~pop;
    end
  end

  // Payload capture on push only
  // Held stable while the slot waits for a grant
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FLOWS; i++) begin
      if (push[i]) begin
        data_q[i] <= in_data[i];
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  // Ready only while the slot is empty
  // A slot freed by a pop takes a new push from the next cycle on
  assign in_ready = ~full_q;

  // Requests come straight from the flags, never from the external valids
  assign req_valid = full_q;
  assign req_data  = data_q;

endmodule : flow_ingress

// ==== flow_pkg.sv ====
package flow_pkg;

  // ------------------------------
  // Flow geometry
  // ------------------------------

  // Number of input flows merged onto the output stream
  localparam int NUM_FLOWS = 4;

  // Width of one payload word
  localparam int PAYLOAD_W = 16;

  // Enough bits to index any flow
  localparam int FLOW_ID_W = $clog2(NUM_FLOWS);

  // ------------------------------
  // Data types
  // ------------------------------

  // One payload word as carried by a flow
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Index of a flow, also the source tag on the output
  typedef logic [FLOW_ID_W-1:0] flow_id_t;

endpackage : flow_pkg

// ==== rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter
  import flow_pkg::*, arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Request vector, one bit per flow
  input  flow_mask_t request,
  // Pointer may move only when this is high
  input  logic       enable_priority_update,
  // One-hot winner among the requests
  output flow_mask_t grant,
  // Flows that would win in this cycle
  output flow_mask_t can_grant
);

  // ------------------------------
  // Priority pointer and winner
  // ------------------------------

  // Flow with the highest priority this cycle
  flow_id_t   ptr_q;
  // Winner as an index and as a one-hot mask
  flow_id_t   win_idx;
  flow_mask_t win_mask;
  logic       win_found;
  // Pointer value one past the winner
  flow_id_t   ptr_next;

  // Scan in circular order starting at the pointer
  // First requesting flow wins
  always_comb begin : pick_winner
    int idx;
    idx       = 0;
    win_idx   = '0;
    win_mask  = '0;
    win_found = 1'b0;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      idx = (int'(ptr_q) + i) % NUM_FLOWS;
      if (!win_found && request[idx]) begin
        win_found     = 1'b1;
        win_idx       = flow_id_t'(idx);
        win_mask[idx] = 1'b1;
      end
    end
  end

  // Round-robin always grants when any request is present
  assign can_grant = win_mask;
  assign grant     = request & can_grant;

  // Wrap past the last flow
  assign ptr_next = (win_idx == flow_id_t'(NUM_FLOWS - 1)) ? '0 :
                    flow_id_t'(win_idx + 1'b1);

  // ------------------------------
  // Pointer update
  // ------------------------------

  // Move only on a real grant with the output able to take it
  // A stalled output keeps the winner at the head of the order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (enable_priority_update && (|grant)) begin
      ptr_q <= ptr_next;
    end
  end

endmodule : rr_arbiter

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_flow_arb -f sim.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_flow_arb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'; then
  exit 0
fi
exit 1

// ==== sim.f ====
flow_pkg.sv
arb_pkg.sv
flow_ingress.sv
rr_arbiter.sv
flow_arb_core.sv
flow_egress.sv
flow_arb_top.sv
flow_arb_chk.sv
flow_arb_monitor.sv
tb_flow_arb.sv

// ==== tb_flow_arb.sv ====
`timescale 1ns/10ps

module tb_flow_arb
  import flow_pkg::*, arb_pkg::*;
();

  // ------------------------------
  // Run constants and signals
  // ------------------------------

  localparam int SEED_INIT      = 32'hd4f83b39;
  localparam int ITEMS_PER_FLOW = 8;
  localparam int TIMEOUT_CYCLES = 200;
  // Payload bits left for the sequence number under the flow tag
  localparam int SEQ_W          = PAYLOAD_W - FLOW_ID_W;

  logic       clk;
  logic       rst_n;
  flow_mask_t in_valid;
  payload_t   in_data [NUM_FLOWS];
  flow_mask_t in_ready;
  logic       out_valid;
  logic       out_ready;
  payload_t   out_data;
  flow_id_t   out_flow;

  int   seed;
  int   tb_errors;
  int   errs_mark;
  int   seq [NUM_FLOWS];
  logic bursts_done;

  flow_arb_top dut_i (.*);
  flow_arb_monitor mon_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int total_errors();
    return tb_errors + mon_i.err_count;
  endfunction

  // Nothing offered, nothing held, every pushed item seen on the output
  function automatic logic is_drained();
    return (in_valid == '0) && (in_ready == '1) && !out_valid &&
           (mon_i.push_count == mon_i.pop_count);
  endfunction

  // Offer one item and hold it until the slot takes it
  // Payload is the flow id on top of a per-flow sequence number
  task automatic push_item(input int f);
    int waited;
    waited = 0;
    in_valid[f] <= 1'b1;
    in_data[f]  <= {flow_id_t'(f), SEQ_W'(seq[f])};
    seq[f] = seq[f] + 1;
    @(posedge clk);
    while (!in_ready[f] && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (!in_ready[f]) begin
      $display("timeout: flow %0d push not accepted in %0d cycles", f, TIMEOUT_CYCLES);
      tb_errors++;
    end
    in_valid[f] <= 1'b0;
  endtask

  // Back-to-back pushes or pushes with random idle cycles between them
  task automatic run_burst(input int f, input logic gaps);
    int idle;
    repeat (ITEMS_PER_FLOW) begin
      idle = gaps ? ($random(seed) & 3) : 0;
      repeat (idle) @(posedge clk);
      push_item(f);
    end
  endtask

  // Random out_ready high about three cycles in four until the bursts end
  task automatic toggle_ready();
    int r;
    int cycles;
    cycles = 0;
    while (!bursts_done && cycles < ITEMS_PER_FLOW * TIMEOUT_CYCLES) begin
      @(posedge clk);
      r = $random(seed);
      out_ready <= (r[1:0] != 2'b00);
      cycles++;
    end
    if (!bursts_done) begin
      $display("timeout: pushes did not finish in %0d cycles",
               ITEMS_PER_FLOW * TIMEOUT_CYCLES);
      tb_errors++;
    end
    out_ready <= 1'b1;
  endtask

  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    while (!is_drained() && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (!is_drained()) begin
      $display("timeout: %s traffic did not drain in %0d cycles", what, TIMEOUT_CYCLES);
      tb_errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, total_errors() - errs_mark);
    errs_mark = total_errors();
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    rst_n     = 1'b0;
    in_valid  = '0;
    out_ready = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      in_data[f] = '0;
      seq[f]     = 0;
    end
    seed        = SEED_INIT;
    tb_errors   = 0;
    errs_mark   = 0;
    bursts_done = 1'b0;
    repeat (10) @(posedge clk);
    rst_n     <= 1'b1;
    out_ready <= 1'b1;

    // All slots free and nothing on the output
    @(posedge clk);
    if (in_ready !== {NUM_FLOWS{1'b1}}) begin
      $display("error at %0t: in_ready expected %b got %b", $time, {NUM_FLOWS{1'b1}}, in_ready);
      tb_errors++;
    end
    if (out_valid !== 1'b0) begin
      $display("error at %0t: out_valid expected 0 got %b", $time, out_valid);
      tb_errors++;
    end
    end_test(1, "reset state");

    for (int f = 0; f < NUM_FLOWS; f++) begin
      run_burst(f, 1'b0);
      wait_drained("single flow");
    end
    end_test(2, "single flow pass-through");

    // All flows contend and order across flows is free
    fork
      run_burst(0, 1'b0);
      run_burst(1, 1'b0);
      run_burst(2, 1'b0);
      run_burst(3, 1'b0);
    join
    wait_drained("round-robin");
    end_test(3, "round-robin sharing");

    fork
      begin
        fork
          run_burst(0, 1'b1);
          run_burst(1, 1'b1);
          run_burst(2, 1'b1);
          run_burst(3, 1'b1);
        join
        bursts_done = 1'b1;
      end
      toggle_ready();
    join
    end_test(4, "back-pressure");

    wait_drained("final");
    end_test(5, "drain");

    $display("summary: %0d pushed, %0d popped, %0d errors",
             mon_i.push_count, mon_i.pop_count, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_flow_arb
